// ==== sources.f ====
frog_pkg.sv
scene_sequencer.sv
object_motion.sv
sprite_scanner.sv
pixel_stage.sv
frog_draw_top.sv
frog_draw_chk.sv
tb_frog_draw.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the frog drawing engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_frog_draw -o sim_frog_draw

./obj_dir/sim_frog_draw | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported errors"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "Simulation stopped without a final result"
    exit 1
fi
echo "Simulation clean"

// ==== tb_frog_draw.sv ====
`timescale 1ns/10ps

module tb_frog_draw;
    import frog_pkg::*;

    localparam int          CLK_HALF     = 50;
    localparam int          NUM_FRAMES   = 8;
    localparam int          DIR_HOLD     = 200000;
    localparam int          MAX_PRINT    = 40;
    localparam int          SCREEN_PIX   = SCREEN_W * SCREEN_H;
    localparam int          WATCHDOG_CYC = 12 * FRAME_TICKS + 3 * SCREEN_PIX + 1000;
    localparam logic [31:0] SEED         = 32'hefec65d7;

    logic   clk    = 1'b0;
    logic   reset  = 1'b1;
    logic   go_key = 1'b0;
    // Down held at the bottom row first, right moves the frog
    move_t  dir    = '{up: 1'b0, down: 1'b1, left: 1'b0, right: 1'b1};
    pixel_t pix;

    int cyc          = 0;
    int go_cyc       = 0;
    int go_count     = 0;
    int screens_done = 0;
    bit check_done   = 1'b0;
    int checks       = 0;
    int errors       = 0;

    frog_draw_top u_frog_draw_top (
        .clk    (clk),
        .reset  (reset),
        .go_key (go_key),
        .dir    (dir),
        .pix    (pix)
    );

    initial begin
        forever #CLK_HALF clk = ~clk;
    end

    // Cycles since reset, in step with the free running frame counter
    always @(posedge clk) begin
        if (reset)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    function automatic int box_w(layer_t layer);
        case (layer)
            LAYER_LOG1, LAYER_LOG2: return LOG_W;
            LAYER_FROG:             return FROG_W;
            default:                return SCREEN_W;
        endcase
    endfunction

    function automatic int box_h(layer_t layer);
        case (layer)
            LAYER_LOG1, LAYER_LOG2: return LOG_H;
            LAYER_FROG:             return FROG_H;
            default:                return SCREEN_H;
        endcase
    endfunction

    function automatic color_t color_for(layer_t layer);
        case (layer)
            LAYER_START: return 3'b001;
            LAYER_OVER:  return 3'b100;
            LAYER_BG:    return 3'b010;
            LAYER_LOG1:  return 3'b110;
            LAYER_LOG2:  return 3'b011;
            default:     return 3'b111;
        endcase
    endfunction

    // Reference pixel for point idx of a pass, raster order with dx fast
    function automatic pixel_t expected_pixel(layer_t layer, positions_t p, int idx);
        pixel_t r;
        int     ox;
        int     oy;
        int     xs;
        int     ys;
        ox = 0;
        oy = 0;
        case (layer)
            LAYER_LOG1: begin
                ox = int'(p.log1_x);
                oy = 80;
            end
            LAYER_LOG2: begin
                ox = int'(p.log2_x);
                oy = 150;
            end
            LAYER_FROG: begin
                ox = int'(p.frog_x);
                oy = int'(p.frog_y);
            end
            default: ;
        endcase
        xs      = (ox + idx % box_w(layer)) % 512;
        ys      = (oy + idx / box_w(layer)) % 512;
        r.plot  = (xs < SCREEN_W);
        r.x     = coord_t'(xs);
        r.y     = coord_t'(ys);
        r.color = color_for(layer);
        return r;
    endfunction

    // One frame of motion, frog held inside its box, logs wrap at 320
    function automatic positions_t next_positions(positions_t p, move_t d);
        positions_t r;
        int         fx;
        int         fy;
        r  = p;
        fx = int'(p.frog_x) + int'(d.right) - int'(d.left);
        fy = int'(p.frog_y) + int'(d.down) - int'(d.up);
        if (fx >= 0 && fx <= SCREEN_W - FROG_W)
            r.frog_x = coord_t'(fx);
        if (fy >= 0 && fy <= SCREEN_H - FROG_H)
            r.frog_y = coord_t'(fy);
        r.log1_x = coord_t'((int'(p.log1_x) + 1) % SCREEN_W);
        r.log2_x = coord_t'((int'(p.log2_x) + SCREEN_W - 1) % SCREEN_W);
        return r;
    endfunction

    task automatic report_mismatch(input string name, input int exp_val, input int got_val);
        errors = errors + 1;
        if (errors <= MAX_PRINT)
            $display("[ERROR] %s exp %h got %h at cycle %0d", name, exp_val, got_val, cyc);
    endtask

    task automatic expect_idle();
        checks = checks + 1;
        assert (!pix.plot) else report_mismatch("pix.plot", 0, int'(pix.plot));
    endtask

    task automatic compare_pixel(input pixel_t e);
        checks = checks + 1;
        assert (pix.plot == e.plot) else report_mismatch("pix.plot", int'(e.plot), int'(pix.plot));
        if (e.plot) begin
            assert (pix.x == e.x) else report_mismatch("pix.x", int'(e.x), int'(pix.x));
            assert (pix.y == e.y) else report_mismatch("pix.y", int'(e.y), int'(pix.y));
            assert (pix.color == e.color)
                else report_mismatch("pix.color", int'(e.color), int'(pix.color));
        end
    endtask

    task automatic wait_go(input int n);
        do begin
            @(negedge clk);
            expect_idle();
        end while (go_count < n);
    endtask

    // Quiet until start, then every point of the box on consecutive cycles
    task automatic check_pass(input layer_t layer, input int start, input positions_t p,
                              output int last);
        int n;
        int i;
        n = box_w(layer) * box_h(layer);
        @(negedge clk);
        while (cyc < start) begin
            expect_idle();
            @(negedge clk);
        end
        for (i = 0; i < n; i++) begin
            if (i > 0)
                @(negedge clk);
            compare_pixel(expected_pixel(layer, p, i));
        end
        last = cyc;
    endtask

    // Next tick at or after the last frog point, dir as seen in that cycle
    task automatic wait_tick(input int last, output move_t d, output int tick);
        tick = last + (FRAME_TICKS - 1) - (last % FRAME_TICKS);
        while (cyc < tick) begin
            @(negedge clk);
            expect_idle();
        end
        d = dir;
    endtask

    task automatic press_go();
        @(posedge clk);
        #1;
        go_key   = 1'b1;
        go_cyc   = cyc;
        go_count = go_count + 1;
        repeat (3) @(posedge clk);
        #1;
        go_key = 1'b0;
    endtask

    initial begin : compare
        positions_t model;
        move_t      d;
        int         start;
        int         last;
        int         tick;
        int         f;
        model = '{frog_x: 9'd144, frog_y: 9'd216, log1_x: 9'd20, log2_x: 9'd120};
        @(negedge reset);
        wait_go(1);
        check_pass(LAYER_START, go_cyc + 3, model, last);
        screens_done = 1;
        wait_go(2);
        check_pass(LAYER_OVER, go_cyc + 3, model, last);
        screens_done = 2;
        wait_go(3);
        start = go_cyc + 3;
        for (f = 0; f < NUM_FRAMES; f++) begin
            check_pass(LAYER_BG, start, model, last);
            check_pass(LAYER_LOG1, last + 2, model, last);
            check_pass(LAYER_LOG2, last + 2, model, last);
            check_pass(LAYER_FROG, last + 2, model, last);
            if (f < NUM_FRAMES - 1) begin
                wait_tick(last, d, tick);
                model = next_positions(model, d);
                start = tick + 3;
            end
        end
        check_done = 1'b1;
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int          hold;
        rnd = $urandom(SEED);
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (20) @(posedge clk);
        press_go();
        wait (screens_done == 1);
        repeat (10) @(posedge clk);
        press_go();
        wait (screens_done == 2);
        repeat (10) @(posedge clk);
        press_go();
        hold = 0;
        while (!check_done) begin
            @(posedge clk);
            hold = hold + 1;
            if (hold == DIR_HOLD) begin
                #1;
                rnd  = $urandom();
                dir  = rnd[3:0];
                hold = 0;
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: the frame sequence did not complete in %0d cycles", WATCHDOG_CYC);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== frog_draw_chk.sv ====
`timescale 1ns/10ps

module frog_draw_chk (
    input logic             clk,
    input logic             reset,
    input frog_pkg::scan_t  scan,
    input frog_pkg::pixel_t pix
);
    import frog_pkg::*;

    // Plot register clears on every reset edge
    plot_low_in_reset: assert property (
        @(posedge clk) reset |=> !pix.plot
    ) else $error("plot strobe high while in reset");

    plot_on_screen: assert property (
        @(posedge clk) disable iff (reset)
        pix.plot |-> (pix.x < coord_t'(SCREEN_W)) && (pix.y < coord_t'(SCREEN_H))
    ) else $error("plotted point off screen, x %h y %h", pix.x, pix.y);

    // Output stage is one register behind the scanner
    plot_from_valid: assert property (
        @(posedge clk) disable iff (reset)
        pix.plot |-> $past(scan.valid)
    ) else $error("plot strobe without a valid scan point one cycle earlier");

endmodule

bind frog_draw_top frog_draw_chk u_frog_draw_chk (
    .clk   (clk),
    .reset (reset),
    .scan  (scan),
    .pix   (pix)
);

// ==== frog_draw_top.sv ====
`timescale 1ns/10ps

module frog_draw_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             go_key,
    input  frog_pkg::move_t  dir,
    output frog_pkg::pixel_t pix
);
    import frog_pkg::*;

    draw_cmd_t  cmd;
    positions_t pos;
    scan_t      scan;
    logic       frame_step;
    logic       pass_done;

    scene_sequencer u_scene_sequencer (
        .clk        (clk),
        .reset      (reset),
        .go_key     (go_key),
        .pass_done  (pass_done),
        .pos        (pos),
        .cmd        (cmd),
        .frame_step (frame_step)
    );

    object_motion u_object_motion (
        .clk        (clk),
        .reset      (reset),
        .frame_step (frame_step),
        .dir        (dir),
        .pos        (pos)
    );

    sprite_scanner u_sprite_scanner (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .scan      (scan),
        .pass_done (pass_done)
    );

    pixel_stage u_pixel_stage (
        .clk   (clk),
        .reset (reset),
        .scan  (scan),
        .pix   (pix)
    );

endmodule

// ==== pixel_stage.sv ====
`timescale 1ns/10ps

module pixel_stage (
    input  logic             clk,
    input  logic             reset,
    input  frog_pkg::scan_t  scan,
    output frog_pkg::pixel_t pix
);
    import frog_pkg::*;

    coord_t x_sum;
    coord_t y_sum;
    logic   on_screen;
    color_t color;

    function automatic color_t layer_color(layer_t layer);
        color_t c;
        case (layer)
            LAYER_START: c = COLOR_START;
            LAYER_OVER:  c = COLOR_OVER;
            LAYER_BG:    c = COLOR_BG;
            LAYER_LOG1:  c = COLOR_LOG1;
            LAYER_LOG2:  c = COLOR_LOG2;
            LAYER_FROG:  c = COLOR_FROG;
            default:     c = '0;
        endcase
        return c;
    endfunction

    // Sums wrap at 512, a log past the right edge lands in the clip range
    always_comb begin
        x_sum     = scan.org_x + scan.dx;
        y_sum     = scan.org_y + scan.dy;
        on_screen = (x_sum < coord_t'(SCREEN_W));
        color     = layer_color(scan.layer);
    end

    always_ff @(posedge clk) begin
        if (reset)
            pix.plot <= 1'b0;
        else
            pix.plot <= scan.valid && on_screen;
    end

    always_ff @(posedge clk) begin
        pix.x     <= x_sum;
        pix.y     <= y_sum;
        pix.color <= color;
    end

endmodule

// ==== sprite_scanner.sv ====
`timescale 1ns/10ps

module sprite_scanner (
    input  logic                clk,
    input  logic                reset,
    input  frog_pkg::draw_cmd_t cmd,
    output frog_pkg::scan_t     scan,
    output logic                pass_done
);
    import frog_pkg::*;

    coord_t size_w_last;
    coord_t size_h_last;
    coord_t w_last;
    coord_t h_last;
    coord_t dx_next;
    coord_t dy_next;

    // Box size of the layer being started
    always_comb begin
        case (cmd.layer)
            LAYER_LOG1, LAYER_LOG2: begin
                size_w_last = coord_t'(LOG_W - 1);
                size_h_last = coord_t'(LOG_H - 1);
            end
            LAYER_FROG: begin
                size_w_last = coord_t'(FROG_W - 1);
                size_h_last = coord_t'(FROG_H - 1);
            end
            default: begin
                size_w_last = coord_t'(SCREEN_W - 1);
                size_h_last = coord_t'(SCREEN_H - 1);
            end
        endcase
    end

    // dx runs fast, dy slow
    always_comb begin
        dx_next = scan.dx + 1'b1;
        dy_next = scan.dy;
        if (scan.dx == w_last) begin
            dx_next = '0;
            dy_next = scan.dy + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scan.valid <= 1'b0;
            scan.last  <= 1'b0;
        end else if (cmd.start) begin
            scan.valid <= 1'b1;
            scan.last  <= 1'b0;
        end else if (scan.valid) begin
            scan.valid <= !scan.last;
            scan.last  <= !scan.last && (dx_next == w_last) && (dy_next == h_last);
        end
    end

    // Latched command and raster position
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            scan.layer <= cmd.layer;
            scan.org_x <= cmd.x;
            scan.org_y <= cmd.y;
            scan.dx    <= '0;
            scan.dy    <= '0;
            w_last     <= size_w_last;
            h_last     <= size_h_last;
        end else if (scan.valid && !scan.last) begin
            scan.dx <= dx_next;
            scan.dy <= dy_next;
        end
    end

    assign pass_done = scan.valid && scan.last;

endmodule

// ==== object_motion.sv ====
`timescale 1ns/10ps

module object_motion (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_step,
    input  frog_pkg::move_t      dir,
    output frog_pkg::positions_t pos
);
    import frog_pkg::*;

    coord_t frog_x_next;
    coord_t frog_y_next;
    coord_t log1_x_next;
    coord_t log2_x_next;

    // One pixel step toward inc or dec, held at 0 and at limit
    function automatic coord_t step_bounded(coord_t v, logic inc, logic dec, coord_t limit);
        coord_t r;
        r = v;
        if (inc && !dec && v < limit)
            r = v + 1'b1;
        else if (dec && !inc && v != '0)
            r = v - 1'b1;
        return r;
    endfunction

    // Frog moves by right minus left, down minus up
    always_comb begin
        frog_x_next = step_bounded(pos.frog_x, dir.right, dir.left, FROG_X_MAX);
        frog_y_next = step_bounded(pos.frog_y, dir.down, dir.up, FROG_Y_MAX);
    end

    // Logs drift in opposite directions and wrap across the screen width
    always_comb begin
        if (pos.log1_x == coord_t'(SCREEN_W - 1))
            log1_x_next = '0;
        else
            log1_x_next = pos.log1_x + 1'b1;

        if (pos.log2_x == '0)
            log2_x_next = coord_t'(SCREEN_W - 1);
        else
            log2_x_next = pos.log2_x - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pos.frog_x <= FROG_X0;
            pos.frog_y <= FROG_Y0;
            pos.log1_x <= LOG1_X0;
            pos.log2_x <= LOG2_X0;
        end else if (frame_step) begin
            pos.frog_x <= frog_x_next;
            pos.frog_y <= frog_y_next;
            pos.log1_x <= log1_x_next;
            pos.log2_x <= log2_x_next;
        end
    end

endmodule

// ==== scene_sequencer.sv ====
`timescale 1ns/10ps

module scene_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 go_key,
    input  logic                 pass_done,
    input  frog_pkg::positions_t pos,
    output frog_pkg::draw_cmd_t  cmd,
    output logic                 frame_step
);
    import frog_pkg::*;

    typedef enum logic [3:0] {
        S_WAIT_START,
        S_START,
        S_WAIT_OVER,
        S_OVER,
        S_WAIT_BG,
        S_BG,
        S_LOG1,
        S_LOG2,
        S_FROG,
        S_WAIT_TICK
    } state_t;

    state_t                 state;
    logic                   go_key_q;
    logic                   go;
    logic [FRAME_CNT_W-1:0] frame_cnt;
    logic                   frame_tick;

    function automatic draw_cmd_t make_cmd(layer_t layer, coord_t x, coord_t y);
        draw_cmd_t c;
        c.start = 1'b1;
        c.layer = layer;
        c.x     = x;
        c.y     = y;
        return c;
    endfunction

    // Go key sampler, one strobe per rising edge
    always_ff @(posedge clk) begin
        go_key_q <= go_key;
    end

    assign go = go_key & ~go_key_q;

    // Free running frame counter
    always_ff @(posedge clk) begin
        if (reset || frame_tick)
            frame_cnt <= '0;
        else
            frame_cnt <= frame_cnt + 1'b1;
    end

    assign frame_tick = (frame_cnt == FRAME_CNT_W'(FRAME_TICKS - 1));

    // Motion happens in the tick cycle, so the next pass sees new positions
    assign frame_step = (state == S_WAIT_TICK) && frame_tick;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_WAIT_START;
            cmd   <= '0;
        end else begin
            cmd.start <= 1'b0;
            case (state)
                S_WAIT_START: if (go) begin
                    cmd   <= make_cmd(LAYER_START, '0, '0);
                    state <= S_START;
                end
                S_START: if (pass_done) state <= S_WAIT_OVER;
                S_WAIT_OVER: if (go) begin
                    cmd   <= make_cmd(LAYER_OVER, '0, '0);
                    state <= S_OVER;
                end
                S_OVER: if (pass_done) state <= S_WAIT_BG;
                S_WAIT_BG: if (go) begin
                    cmd   <= make_cmd(LAYER_BG, '0, '0);
                    state <= S_BG;
                end
                // Frame loop, each pass chained off the previous pass_done
                S_BG: if (pass_done) begin
                    cmd   <= make_cmd(LAYER_LOG1, pos.log1_x, LOG1_Y);
                    state <= S_LOG1;
                end
                S_LOG1: if (pass_done) begin
                    cmd   <= make_cmd(LAYER_LOG2, pos.log2_x, LOG2_Y);
                    state <= S_LOG2;
                end
                S_LOG2: if (pass_done) begin
                    cmd   <= make_cmd(LAYER_FROG, pos.frog_x, pos.frog_y);
                    state <= S_FROG;
                end
                S_FROG: if (pass_done) state <= S_WAIT_TICK;
                S_WAIT_TICK: if (frame_tick) begin
                    cmd   <= make_cmd(LAYER_BG, '0, '0);
                    state <= S_BG;
                end
                default: state <= S_WAIT_START;
            endcase
        end
    end

endmodule

// ==== frog_pkg.sv ====
package frog_pkg;

    // Screen geometry
    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 240;
    localparam int COORD_W  = 9;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [2:0]         color_t;

    // Layers drawn by the engine, one per draw pass
    typedef enum logic [2:0] {
        LAYER_START,
        LAYER_OVER,
        LAYER_BG,
        LAYER_LOG1,
        LAYER_LOG2,
        LAYER_FROG
    } layer_t;

    // Sprite boxes
    localparam int LOG_W  = 96;
    localparam int LOG_H  = 40;
    localparam int FROG_W = 32;
    localparam int FROG_H = 24;

    // Solid layer colors, RGB one bit each
    localparam color_t COLOR_START = 3'b001;
    localparam color_t COLOR_OVER  = 3'b100;
    localparam color_t COLOR_BG    = 3'b010;
    localparam color_t COLOR_LOG1  = 3'b110;
    localparam color_t COLOR_LOG2  = 3'b011;
    localparam color_t COLOR_FROG  = 3'b111;

    // Start positions and frog limits
    localparam coord_t FROG_X0    = 9'd144;
    localparam coord_t FROG_Y0    = 9'd216;
    localparam coord_t LOG1_X0    = 9'd20;
    localparam coord_t LOG1_Y     = 9'd80;
    localparam coord_t LOG2_X0    = 9'd120;
    localparam coord_t LOG2_Y     = 9'd150;
    localparam coord_t FROG_X_MAX = coord_t'(SCREEN_W - FROG_W);
    localparam coord_t FROG_Y_MAX = coord_t'(SCREEN_H - FROG_H);

    // Frame tick period in clock cycles
    localparam int FRAME_TICKS = 100000;
    localparam int FRAME_CNT_W = $clog2(FRAME_TICKS);

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } move_t;

    typedef struct packed {
        logic   start;
        layer_t layer;
        coord_t x;
        coord_t y;
    } draw_cmd_t;

    typedef struct packed {
        logic   valid;
        layer_t layer;
        coord_t org_x;
        coord_t org_y;
        coord_t dx;
        coord_t dy;
        logic   last;
    } scan_t;

    typedef struct packed {
        logic   plot;
        coord_t x;
        coord_t y;
        color_t color;
    } pixel_t;

    typedef struct packed {
        coord_t frog_x;
        coord_t frog_y;
        coord_t log1_x;
        coord_t log2_x;
    } positions_t;

endpackage
